/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the syscfg testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_syscfg \
    -f src.f \
    -o tb_syscfg
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/tb_syscfg)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" <<< "$output"; then
    exit 0
fi
exit 1

/* source/syscfg_apb_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module syscfg_apb_decoder #(
    parameter int N_TARGETS = 4
) (
    input  wire logic                                    seq,
    input  wire logic                                    rst_n,

    // Host side request
    input  wire logic [syscfg_pkg::ADDR_WIDTH-1:0]       paddr,
    input  wire logic                                    psel,
    input  wire logic                                    penable,

    // Target side, flattened per target
    output logic      [N_TARGETS-1:0]                    tgt_psel,
    input  wire logic [N_TARGETS-1:0]                    tgt_pready,
    input  wire logic [N_TARGETS*syscfg_pkg::DATA_WIDTH-1:0] tgt_prdata,
    input  wire logic [N_TARGETS-1:0]                    tgt_pslverr,

    // Host side response
    output logic                                         pready,
    output logic      [syscfg_pkg::DATA_WIDTH-1:0]       prdata,
    output logic                                         pslverr
);
    import syscfg_pkg::*;

    localparam int IDX_WIDTH = ADDR_WIDTH - TGT_SEL_LSB;

    logic [IDX_WIDTH-1:0] tgt_idx;
    logic                 mapped;
    logic                 err_ready;

    assign tgt_idx = paddr[ADDR_WIDTH-1:TGT_SEL_LSB];

    // Anything past the last target is answered here
    assign mapped = int'(tgt_idx) < N_TARGETS;

    // Responder for unmapped targets, same one-cycle handshake as a target
    always_ff @(posedge seq) begin
        if (!rst_n) begin
            err_ready <= 1'b0;
        end
        else if (psel && !mapped && !err_ready) begin
            err_ready <= 1'b1;
        end
        else if (psel && penable && err_ready) begin
            err_ready <= 1'b0;
        end
    end

    // Select and response mux by target index
    always_comb begin
        tgt_psel = '0;
        pready   = err_ready;
        prdata   = '0;
        pslverr  = err_ready;

        for (int i = 0; i < N_TARGETS; i++) begin
            if (tgt_idx == IDX_WIDTH'(i)) begin
                tgt_psel[i] = psel;
                pready      = tgt_pready[i];
                prdata      = tgt_prdata[i*DATA_WIDTH +: DATA_WIDTH];
                pslverr     = tgt_pslverr[i];
            end
        end
    end

endmodule

`default_nettype wire

/* source/syscfg_irq_collector.sv */
`timescale 1ns/100ps
`default_nettype none

module syscfg_irq_collector #(
    parameter int N_TARGETS = 4
) (
    input  wire logic                 seq,
    input  wire logic                 rst_n,

    input  wire logic [N_TARGETS-1:0] tgt_irq,
    input  wire logic [N_TARGETS-1:0] irq_clr,

    output logic      [N_TARGETS-1:0] irq_pending,
    output logic                      irq
);

    // Sticky pending bits, a live source wins over a clear
    always_ff @(posedge seq) begin
        if (!rst_n) begin
            irq_pending <= '0;
        end
        else begin
            irq_pending <= (irq_pending & ~irq_clr) | tgt_irq;
        end
    end

    // Summary interrupt, one cycle behind the pending bits
    always_ff @(posedge seq) begin
        if (!rst_n) begin
            irq <= 1'b0;
        end
        else begin
            irq <= |irq_pending;
        end
    end

endmodule

`default_nettype wire

/* source/syscfg_pkg.sv */
`default_nettype none

package syscfg_pkg;

    // APB bus widths
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Interrupt sources per target, also the used IER bits
    localparam int IRQ_WIDTH = 8;

    // Register index within a target window, from byte address bits 3:2
    localparam logic [1:0] REG_SR  = 2'd0;
    localparam logic [1:0] REG_MR  = 2'd1;
    localparam logic [1:0] REG_BAR = 2'd2;
    localparam logic [1:0] REG_IER = 2'd3;

    // Lowest address bit of the target index, 16 bytes per target
    localparam int TGT_SEL_LSB = 4;

    // MR opcode, reused as sequencer state
    typedef enum logic [3:0] {
        IDLE   = 4'd0,
        RESUME = 4'd1,
        PAUSE  = 4'd2,
        STOP   = 4'd3,
        RESET  = 4'd4
    } action_t;

endpackage

`default_nettype wire

/* source/syscfg_target_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module syscfg_target_ctrl #(
    parameter bit EN_BOOTSTRAP = 1'b0,
    parameter bit EN_BOOT_ADDR = 1'b0,
    parameter bit EN_IRQ       = 1'b0
) (
    input  wire logic                              seq,
    input  wire logic                              rst_n,

    // APB responder
    input  wire logic [syscfg_pkg::ADDR_WIDTH-1:0] paddr,
    input  wire logic                              psel,
    input  wire logic                              penable,
    input  wire logic                              pwrite,
    input  wire logic [syscfg_pkg::DATA_WIDTH-1:0] pwdata,
    input  wire logic [syscfg_pkg::STRB_WIDTH-1:0] pstrb,
    output logic                                   pready,
    output logic      [syscfg_pkg::DATA_WIDTH-1:0] prdata,
    output logic                                   pslverr,

    input  wire logic [syscfg_pkg::IRQ_WIDTH-1:0]  irq_vec,

    // Target core control
    output logic                                   tgt_rst,
    output logic                                   tgt_pause_req,
    input  wire logic                              tgt_pause_ack,
    output logic      [syscfg_pkg::DATA_WIDTH-1:0] tgt_boot_addr,
    output logic                                   tgt_irq
);
    import syscfg_pkg::*;

    localparam int REG_LSB = $clog2(STRB_WIDTH);

    action_t                 action;
    action_t                 state;
    logic                    paused;
    logic                    stopped;
    logic [DATA_WIDTH-1:0]   bar;
    logic [IRQ_WIDTH-1:0]    ier;

    logic [DATA_WIDTH-1:0]   sr;
    logic [DATA_WIDTH-1:0]   mr;
    logic [DATA_WIDTH-1:0]   mask;
    logic [1:0]              reg_idx;
    logic                    busy;

    assign sr = {{(DATA_WIDTH-2){1'b0}}, stopped, paused};
    assign mr = {{(DATA_WIDTH-4){1'b0}}, action};

    assign reg_idx = paddr[TGT_SEL_LSB-1:REG_LSB];

    // MR and BAR are locked while an action is pending or running
    assign busy = (state != IDLE) || (action != IDLE);

    always_comb begin
        for (int i = 0; i < STRB_WIDTH; i++) begin
            mask[i*8 +: 8] = pstrb[i] ? 8'hff : 8'h00;
        end
    end

    assign tgt_boot_addr = bar;
    assign tgt_irq       = EN_IRQ ? |(ier & irq_vec) : 1'b0;

    // APB register access
    always_ff @(posedge seq) begin
        if (!rst_n) begin
            action  <= IDLE;
            bar     <= '0;
            ier     <= '0;
            prdata  <= '0;
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end
        else if (psel && !pready) begin
            // Every access is answered on this edge
            pready <= 1'b1;

            case (reg_idx)
                REG_SR: begin
                    if (pwrite) begin
                        pslverr <= 1'b1;
                    end
                    else begin
                        prdata <= sr;
                    end
                end

                REG_MR: begin
                    if (!pwrite) begin
                        prdata <= mr;
                    end
                    else if (busy) begin
                        pslverr <= 1'b1;
                    end
                    else begin
                        action <= action_t'(pwdata[3:0] & mask[3:0]);
                    end
                end

                REG_BAR: begin
                    if (!EN_BOOT_ADDR) begin
                        pslverr <= 1'b1;
                    end
                    else if (!pwrite) begin
                        prdata <= bar;
                    end
                    else if (busy) begin
                        pslverr <= 1'b1;
                    end
                    else begin
                        bar <= (pwdata & mask) | (bar & ~mask);
                    end
                end

                default: begin
                    // IER
                    if (!EN_IRQ) begin
                        pslverr <= 1'b1;
                    end
                    else if (pwrite) begin
                        ier <= (pwdata[IRQ_WIDTH-1:0] & mask[IRQ_WIDTH-1:0]) |
                               (ier & ~mask[IRQ_WIDTH-1:0]);
                    end
                    else begin
                        prdata <= {{(DATA_WIDTH-IRQ_WIDTH){1'b0}}, ier};
                    end
                end
            endcase
        end
        else if (psel && penable && pready) begin
            // Access done, sequencer has taken the action by now
            prdata  <= '0;
            pready  <= 1'b0;
            pslverr <= 1'b0;
            action  <= IDLE;
        end
    end

    // Sequencer driving the core reset and pause handshake
    always_ff @(posedge seq) begin
        if (!rst_n) begin
            tgt_rst       <= 1'b1;
            tgt_pause_req <= 1'b1;
            state         <= EN_BOOTSTRAP ? RESUME : IDLE;
            paused        <= 1'b1;
            stopped       <= 1'b1;
        end
        else begin
            case (state)
                RESUME: begin
                    tgt_rst       <= 1'b0;
                    tgt_pause_req <= 1'b0;
                    // Running once both sides of the handshake are low
                    if (!tgt_pause_req && !tgt_pause_ack) begin
                        paused  <= 1'b0;
                        stopped <= 1'b0;
                        state   <= IDLE;
                    end
                end

                PAUSE: begin
                    tgt_pause_req <= 1'b1;
                    if (tgt_pause_req && tgt_pause_ack) begin
                        paused <= 1'b1;
                        state  <= IDLE;
                    end
                end

                STOP, RESET: begin
                    tgt_pause_req <= 1'b1;
                    // Core is held in reset only after it has paused
                    if (tgt_pause_req && tgt_pause_ack) begin
                        tgt_rst <= 1'b1;
                        paused  <= 1'b1;
                        stopped <= 1'b1;
                        state   <= (state == RESET) ? RESUME : IDLE;
                    end
                end

                default: begin
                    state <= action;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/syscfg_top.sv */
`timescale 1ns/100ps
`default_nettype none

module syscfg_top #(
    parameter int N_TARGETS    = 4,
    parameter bit EN_BOOTSTRAP = 1'b1,
    parameter bit EN_BOOT_ADDR = 1'b1,
    parameter bit EN_IRQ       = 1'b1
) (
    input  wire logic                                         seq,
    input  wire logic                                         rst_n,

    // APB host port
    input  wire logic [syscfg_pkg::ADDR_WIDTH-1:0]            paddr,
    input  wire logic                                         psel,
    input  wire logic                                         penable,
    input  wire logic                                         pwrite,
    input  wire logic [syscfg_pkg::DATA_WIDTH-1:0]            pwdata,
    input  wire logic [syscfg_pkg::STRB_WIDTH-1:0]            pstrb,
    output logic                                              pready,
    output logic      [syscfg_pkg::DATA_WIDTH-1:0]            prdata,
    output logic                                              pslverr,

    // Interrupt sources and clears
    input  wire logic [N_TARGETS*syscfg_pkg::IRQ_WIDTH-1:0]   irq_vec,
    input  wire logic [N_TARGETS-1:0]                         irq_clr,

    // Per target core control
    output logic      [N_TARGETS-1:0]                         tgt_rst,
    output logic      [N_TARGETS-1:0]                         tgt_pause_req,
    input  wire logic [N_TARGETS-1:0]                         tgt_pause_ack,
    output logic      [N_TARGETS*syscfg_pkg::DATA_WIDTH-1:0]  tgt_boot_addr,

    output logic      [N_TARGETS-1:0]                         irq_pending,
    output logic                                              irq
);
    import syscfg_pkg::*;

    logic [N_TARGETS-1:0]            tgt_psel;
    logic [N_TARGETS-1:0]            tgt_pready;
    logic [N_TARGETS*DATA_WIDTH-1:0] tgt_prdata;
    logic [N_TARGETS-1:0]            tgt_pslverr;
    logic [N_TARGETS-1:0]            tgt_irq;

    syscfg_apb_decoder #(
        .N_TARGETS (N_TARGETS)
    ) u_decoder (
        .seq         (seq),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .tgt_psel    (tgt_psel),
        .tgt_pready  (tgt_pready),
        .tgt_prdata  (tgt_prdata),
        .tgt_pslverr (tgt_pslverr),
        .pready      (pready),
        .prdata      (prdata),
        .pslverr     (pslverr)
    );

    // One controller per target core
    for (genvar i = 0; i < N_TARGETS; i++) begin : g_tgt
        syscfg_target_ctrl #(
            .EN_BOOTSTRAP (EN_BOOTSTRAP),
            .EN_BOOT_ADDR (EN_BOOT_ADDR),
            .EN_IRQ       (EN_IRQ)
        ) u_target_ctrl (
            .seq           (seq),
            .rst_n         (rst_n),
            .paddr         (paddr),
            .psel          (tgt_psel[i]),
            .penable       (penable),
            .pwrite        (pwrite),
            .pwdata        (pwdata),
            .pstrb         (pstrb),
            .pready        (tgt_pready[i]),
            .prdata        (tgt_prdata[i*DATA_WIDTH +: DATA_WIDTH]),
            .pslverr       (tgt_pslverr[i]),
            .irq_vec       (irq_vec[i*IRQ_WIDTH +: IRQ_WIDTH]),
            .tgt_rst       (tgt_rst[i]),
            .tgt_pause_req (tgt_pause_req[i]),
            .tgt_pause_ack (tgt_pause_ack[i]),
            .tgt_boot_addr (tgt_boot_addr[i*DATA_WIDTH +: DATA_WIDTH]),
            .tgt_irq       (tgt_irq[i])
        );
    end

    syscfg_irq_collector #(
        .N_TARGETS (N_TARGETS)
    ) u_irq_collector (
        .seq         (seq),
        .rst_n       (rst_n),
        .tgt_irq     (tgt_irq),
        .irq_clr     (irq_clr),
        .irq_pending (irq_pending),
        .irq         (irq)
    );

endmodule

`default_nettype wire

/* src.f */
+incdir+tests
source/syscfg_pkg.sv
source/syscfg_apb_decoder.sv
source/syscfg_target_ctrl.sv
source/syscfg_irq_collector.sv
source/syscfg_top.sv
tests/target_core_model.sv
tests/tb_syscfg.sv

/* tests/target_core_model.sv */
`timescale 1ns/100ps
`default_nettype none

module target_core_model (
    input  wire logic seq,
    input  wire logic tgt_pause_req,
    output logic      tgt_pause_ack
);

    int unsigned wait_cnt;

    initial begin
        tgt_pause_ack = 1'b0;
        wait_cnt      = 0;
    end

    // Ack follows req after 1 to 8 cycles, four-phase
    always @(posedge seq) begin
        if (tgt_pause_req == tgt_pause_ack) begin
            wait_cnt <= 0;
        end
        else if (wait_cnt == 0) begin
            wait_cnt <= 1 + ($urandom % 8);
        end
        else if (wait_cnt == 1) begin
            tgt_pause_ack <= tgt_pause_req;
            wait_cnt      <= 0;
        end
        else begin
            wait_cnt <= wait_cnt - 1;
        end
    end

endmodule

`default_nettype wire

/* tests/tb_syscfg_tasks.svh */
`ifndef TB_SYSCFG_TASKS_SVH
`define TB_SYSCFG_TASKS_SVH

// Byte address of register r in target k
function automatic logic [15:0] reg_addr(input int k, input logic [1:0] r);
    return 16'(k << TGT_SEL_LSB) | {12'h000, r, 2'b00};
endfunction

// One APB transfer, setup then access, waits for pready
task automatic apb_access(input logic wr, input logic [15:0] addr,
                          input logic [31:0] data, input logic [3:0] strb,
                          output logic [31:0] rdata, output logic err);
    int n;
    n = 0;
    @(posedge seq);
    paddr   <= addr;
    pwrite  <= wr;
    pwdata  <= data;
    pstrb   <= strb;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge seq);
    penable <= 1'b1;
    @(negedge seq);
    while (!pready && n < 16) begin
        n++;
        @(negedge seq);
    end
    if (!pready) begin
        $display("APB transfer to 0x%04h got no pready", addr);
        errors++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge seq);
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

task automatic apb_write(input logic [15:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, output logic err);
    logic [31:0] dummy;
    apb_access(1'b1, addr, data, strb, dummy, err);
endtask

task automatic apb_read(input logic [15:0] addr, output logic [31:0] rdata,
                        output logic err);
    apb_access(1'b0, addr, 32'h0, 4'h0, rdata, err);
endtask

// Reads SR of target k until it matches, gives up after max_reads
task automatic wait_sr(input int k, input logic [31:0] exp, input int max_reads);
    logic [31:0] d;
    logic        e;
    int          n;
    n = 0;
    d = ~exp;
    while (d != exp && n < max_reads) begin
        apb_read(reg_addr(k, REG_SR), d, e);
        n++;
    end
    if (d != exp) begin
        $display("Target %0d status never reached 0x%08h", k, exp);
        errors++;
    end
endtask

`endif

/* tests/tb_syscfg.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_syscfg;
    import syscfg_pkg::*;

    localparam int N_TGT = 4;
    // Cycle budgets per test
    localparam int BUDGET_BOOT = 200;
    localparam int BUDGET_REGS = 300;
    localparam int BUDGET_ERR  = 400;
    localparam int BUDGET_SEQ  = 600;
    localparam int BUDGET_IRQ  = 200;
    // Watchdog allows twice their sum plus margin
    localparam int WATCHDOG_CYCLES =
        2 * (BUDGET_BOOT + BUDGET_REGS + BUDGET_ERR + BUDGET_SEQ + BUDGET_IRQ) + 600;

    logic                    seq;
    logic                    rst_n;
    logic [15:0]             paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [31:0]             pwdata;
    logic [3:0]              pstrb;
    logic                    pready;
    logic [31:0]             prdata;
    logic                    pslverr;
    logic [N_TGT*8-1:0]      irq_vec;
    logic [N_TGT-1:0]        irq_clr;
    logic [N_TGT-1:0]        tgt_rst;
    logic [N_TGT-1:0]        tgt_pause_req;
    logic [N_TGT-1:0]        tgt_pause_ack;
    logic [N_TGT*32-1:0]     tgt_boot_addr;
    logic [N_TGT-1:0]        irq_pending;
    logic                    irq;

    int errors;
    int checks;
    int tests;
    int test_start_errs;

    syscfg_top #(
        .N_TARGETS    (N_TGT),
        .EN_BOOTSTRAP (1'b1),
        .EN_BOOT_ADDR (1'b1),
        .EN_IRQ       (1'b1)
    ) u_syscfg_top (
        .seq           (seq),
        .rst_n         (rst_n),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .pstrb         (pstrb),
        .pready        (pready),
        .prdata        (prdata),
        .pslverr       (pslverr),
        .irq_vec       (irq_vec),
        .irq_clr       (irq_clr),
        .tgt_rst       (tgt_rst),
        .tgt_pause_req (tgt_pause_req),
        .tgt_pause_ack (tgt_pause_ack),
        .tgt_boot_addr (tgt_boot_addr),
        .irq_pending   (irq_pending),
        .irq           (irq)
    );

    for (genvar i = 0; i < N_TGT; i++) begin : g_core
        target_core_model u_core (
            .seq           (seq),
            .tgt_pause_req (tgt_pause_req[i]),
            .tgt_pause_ack (tgt_pause_ack[i])
        );

        // Req may only drop from a paused core once it has acked
        assert property (@(posedge seq) disable iff (!rst_n)
            $fell(tgt_pause_req[i]) |->
                $past(tgt_pause_ack[i] || !u_syscfg_top.g_tgt[i].u_target_ctrl.paused))
        else begin
            $display("Target %0d dropped pause request before the core acked", i);
            errors++;
        end
    end

    // Quiet bus during reset
    assert property (@(posedge seq) (!rst_n && $past(!rst_n)) |-> (!pready && !pslverr))
    else begin
        $display("Response seen on the bus during reset");
        errors++;
    end

    // pready rises one edge after setup and lasts one cycle
    assert property (@(posedge seq) disable iff (!rst_n) (psel && !penable) |=> pready)
    else begin
        $display("No pready one edge after the setup phase");
        errors++;
    end

    assert property (@(posedge seq) disable iff (!rst_n) pready |=> !pready)
    else begin
        $display("pready held for more than one cycle");
        errors++;
    end

    `include "tb_syscfg_tasks.svh"

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got == exp)
        else begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        string verdict;
        tests++;
        if (errors == test_start_errs) begin
            verdict = "ok";
        end
        else begin
            verdict = "errors";
        end
        $display("%s %s", name, verdict);
        test_start_errs = errors;
    endtask

    initial begin
        seq = 1'b0;
        forever #20 seq = ~seq;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge seq);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [31:0] d;
        logic        e;
        void'($urandom(32'h15c5_3351));
        errors = 0;
        checks = 0;
        tests = 0;
        test_start_errs = 0;
        rst_n = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        pstrb = '0;
        irq_vec = '0;
        irq_clr = '0;
        repeat (16) @(posedge seq);
        rst_n <= 1'b1;

        // Bootstrap resumes every core
        for (int k = 0; k < N_TGT; k++) begin
            wait_sr(k, 32'h0, 20);
            check_val($sformatf("tgt_rst[%0d]", k), 32'(tgt_rst[k]), 32'h0);
        end
        finish_test("boot");

        // BAR partial strobes and IER masking
        apb_write(reg_addr(1, REG_BAR), 32'h1122_3344, 4'hf, e);
        apb_write(reg_addr(1, REG_BAR), 32'haabb_ccdd, 4'b0101, e);
        apb_read(reg_addr(1, REG_BAR), d, e);
        check_val("bar", d, 32'h11bb_33dd);
        check_val("tgt_boot_addr", tgt_boot_addr[32 +: 32], 32'h11bb_33dd);
        apb_write(reg_addr(1, REG_IER), 32'hffff_ffa5, 4'b0001, e);
        apb_write(reg_addr(1, REG_IER), 32'h0000_5a00, 4'b0010, e);
        apb_read(reg_addr(1, REG_IER), d, e);
        check_val("ier", d, 32'h0000_00a5);
        apb_write(reg_addr(1, REG_IER), 32'h0, 4'hf, e);
        finish_test("registers");

        // Error responses
        apb_write(reg_addr(0, REG_SR), 32'h3, 4'hf, e);
        check_val("pslverr sr write", 32'(e), 32'h1);
        apb_read(16'h0040, d, e);
        check_val("pslverr tgt 4", 32'(e), 32'h1);
        apb_write(16'h0084, 32'h1, 4'hf, e);
        check_val("pslverr tgt 8", 32'(e), 32'h1);
        apb_write(reg_addr(3, REG_MR), 32'(PAUSE), 4'hf, e);
        apb_write(reg_addr(3, REG_BAR), 32'h1234_5678, 4'hf, e);
        check_val("pslverr bar busy", 32'(e), 32'h1);
        wait_sr(3, 32'h1, 20);
        apb_write(reg_addr(3, REG_MR), 32'(RESUME), 4'hf, e);
        wait_sr(3, 32'h0, 20);
        apb_read(reg_addr(3, REG_BAR), d, e);
        check_val("bar after refusal", d, 32'h0);
        finish_test("errors");

        // Pause, stop and reset on target 2
        apb_write(reg_addr(2, REG_MR), 32'(PAUSE), 4'hf, e);
        wait_sr(2, 32'h1, 20);
        check_val("tgt_rst[2] paused", 32'(tgt_rst[2]), 32'h0);
        apb_write(reg_addr(2, REG_MR), 32'(STOP), 4'hf, e);
        wait_sr(2, 32'h3, 20);
        check_val("tgt_rst[2] stopped", 32'(tgt_rst[2]), 32'h1);
        apb_write(reg_addr(2, REG_MR), 32'(RESET), 4'hf, e);
        wait_sr(2, 32'h0, 20);
        check_val("tgt_rst[2] reset", 32'(tgt_rst[2]), 32'h0);
        finish_test("sequencing");

        // Target 2 interrupt stays pending until cleared after the source drops
        apb_write(reg_addr(2, REG_IER), 32'h0000_0001, 4'hf, e);
        @(posedge seq);
        irq_vec[16] <= 1'b1;
        repeat (2) @(posedge seq);
        @(negedge seq);
        check_val("irq_pending", 32'(irq_pending), 32'h4);
        check_val("irq", 32'(irq), 32'h1);
        @(posedge seq);
        irq_clr[2] <= 1'b1;
        @(posedge seq);
        irq_clr[2] <= 1'b0;
        @(negedge seq);
        check_val("irq_pending live", 32'(irq_pending), 32'h4);
        @(posedge seq);
        irq_vec[16] <= 1'b0;
        @(posedge seq);
        irq_clr[2] <= 1'b1;
        @(posedge seq);
        irq_clr[2] <= 1'b0;
        @(negedge seq);
        check_val("irq_pending cleared", 32'(irq_pending), 32'h0);
        check_val("irq lag", 32'(irq), 32'h1);
        @(negedge seq);
        check_val("irq cleared", 32'(irq), 32'h0);
        finish_test("interrupts");

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end
        else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
